/* hdl/spart_pkg.sv */
package spart_pkg;

	////////////////////////////////////////////////////////////
	// cache side request
	////////////////////////////////////////////////////////////

	// meaning of the request rw bit
	typedef enum logic {
		IO_READ  = 1'b0,
		IO_WRITE = 1'b1
	} io_op_t;

	// one single word request from the cache controller
	typedef struct packed {
		io_op_t      op;
		logic [27:0] addr;
		logic [31:0] wr_data;
	} io_req_t;

	// status register bits, lsb is tx_idle
	typedef struct packed {
		logic overrun;
		logic rx_full;
		logic tx_idle;
	} spart_status_t;

	////////////////////////////////////////////////////////////
	// serial engine states
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	////////////////////////////////////////////////////////////
	// address map and baud timing
	////////////////////////////////////////////////////////////

	localparam logic [27:0] ADDR_DATA   = 28'h800_0000;
	localparam logic [27:0] ADDR_STATUS = 28'h800_0001;

	// clocks per oversample tick
	localparam int BAUD_DIV   = 4;
	// ticks per serial bit
	localparam int OVERSAMPLE = 16;
	localparam int BIT_CLKS   = BAUD_DIV * OVERSAMPLE;
	localparam int HALF_BIT   = OVERSAMPLE / 2;

	// counter widths
	localparam int BAUD_CNT_W = $clog2(BAUD_DIV);
	localparam int OS_CNT_W   = $clog2(OVERSAMPLE);

endpackage

/* hdl/spart_cache_interface.sv */
`timescale 1ns/1ps

module spart_cache_interface (
	input  logic                    clk,
	input  logic                    rst,

	// cache controller side
	input  spart_pkg::io_req_t      io_req,
	input  logic                    io_valid,
	output logic                    io_ready,
	output logic [31:0]             io_rd_data,

	// transmitter
	output logic                    tx_start,
	output logic [7:0]              tx_byte,
	input  logic                    tx_idle,

	// receiver
	input  logic [7:0]              rx_byte,
	input  spart_pkg::spart_status_t rx_status,
	output logic                    rx_take,
	output logic                    status_clear
);
	import spart_pkg::*;

	logic          is_write;
	logic          is_status;
	logic          xfer;
	spart_status_t status;

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////

	assign is_write  = (io_req.op == IO_WRITE);
	// only the status address is special
	// everything else falls through to the data register
	assign is_status = (io_req.addr == ADDR_STATUS);

	// writes wait for an idle transmitter
	// data reads wait for a held byte
	// status reads never stall
	always_comb begin
		if (is_write) begin
			io_ready = tx_idle;
		end else if (is_status) begin
			io_ready = 1'b1;
		end else begin
			io_ready = rx_status.rx_full;
		end
	end

	assign xfer = io_valid && io_ready;

	////////////////////////////////////////////////////////////
	// strobes to the engines
	////////////////////////////////////////////////////////////

	// one cycle each, only on the transfer edge
	assign tx_start     = xfer && is_write;
	assign rx_take      = xfer && !is_write && !is_status;
	assign status_clear = xfer && !is_write && is_status;

	// low byte of the write word goes out
	assign tx_byte = io_req.wr_data[7:0];

	////////////////////////////////////////////////////////////
	// read data
	////////////////////////////////////////////////////////////

	// tx_idle comes from the transmitter, the rest from rx
	always_comb begin
		status         = rx_status;
		status.tx_idle = tx_idle;
	end

	// valid in the transfer cycle itself
	assign io_rd_data = is_status ? {29'd0, status} : {24'd0, rx_byte};

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// a start is only issued to an idle tx, which then goes busy
	a_tx_start_idle: assert property (
		@(posedge clk) disable iff (rst)
		tx_start |-> tx_idle ##1 !tx_idle
	);

	// requester keeps a stalled request in place
	a_req_stable: assert property (
		@(posedge clk) disable iff (rst)
		io_valid && !io_ready |=> io_valid && $stable(io_req)
	);

endmodule

/* hdl/spart_baud_gen.sv */
`timescale 1ns/1ps

module spart_baud_gen (
	input  logic clk,
	input  logic rst,
	output logic tick
);
	import spart_pkg::*;

	// free running phase within one tick period
	logic [BAUD_CNT_W-1:0] cnt;
	logic                  wrap;

	////////////////////////////////////////////////////////////
	// divider
	////////////////////////////////////////////////////////////

	// last count before rolling over
	assign wrap = (cnt == BAUD_CNT_W'(BAUD_DIV - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (wrap) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// one clock wide pulse per period
	// shared by tx and rx so both engines stay in step
	assign tick = wrap;

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// ticks are exactly BAUD_DIV clocks apart
	a_tick_period: assert property (
		@(posedge clk) disable iff (rst)
		tick |=> (!tick) [* BAUD_DIV - 1] ##1 tick
	);

endmodule

/* hdl/spart_tx.sv */
`timescale 1ns/1ps

module spart_tx (
	input  logic       clk,
	input  logic       rst,
	input  logic       tick,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       tx_idle,
	output logic       txd
);
	import spart_pkg::*;

	tx_state_t           state;
	logic [7:0]          shreg;
	logic [OS_CNT_W-1:0] os_cnt;
	logic [2:0]          bit_cnt;
	// byte latched, start bit not yet on the line
	logic                pend;
	logic                bit_end;

	// last tick of the current bit
	assign bit_end = tick && (os_cnt == OS_CNT_W'(OVERSAMPLE - 1));
	assign tx_idle = (state == TX_IDLE);

	////////////////////////////////////////////////////////////
	// frame sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= TX_IDLE;
			txd     <= 1'b1;
			os_cnt  <= '0;
			bit_cnt <= '0;
			pend    <= 1'b0;
		end else begin
			// oversample count wraps on its own every bit
			if (tick) begin
				os_cnt <= os_cnt + 1'b1;
			end
			case (state)
				TX_IDLE: begin
					txd <= 1'b1;
					if (tx_start) begin
						state <= TX_START;
						pend  <= 1'b1;
					end
				end
				TX_START: begin
					if (tick && pend) begin
						// start bit begins on the next tick
						pend   <= 1'b0;
						txd    <= 1'b0;
						os_cnt <= '0;
					end else if (bit_end) begin
						state   <= TX_DATA;
						bit_cnt <= '0;
						txd     <= shreg[0];
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						if (bit_cnt == 3'd7) begin
							state <= TX_STOP;
							txd   <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							txd     <= shreg[1];
						end
					end
				end
				TX_STOP: begin
					// line already high, hold it one full bit
					if (bit_end) begin
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// lsb first shifter
	always_ff @(posedge clk) begin
		if (tx_idle && tx_start) begin
			shreg <= tx_byte;
		end else if (state == TX_DATA && bit_end) begin
			shreg <= shreg >> 1;
		end
	end

	// line is at mark whenever nothing is being sent
	a_idle_mark: assert property (
		@(posedge clk) disable iff (rst)
		state == TX_IDLE |-> txd
	);

endmodule

/* hdl/spart_rx.sv */
`timescale 1ns/1ps

module spart_rx (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     tick,
	input  logic                     rxd,
	input  logic                     rx_take,
	input  logic                     status_clear,
	output logic [7:0]               rx_byte,
	output spart_pkg::spart_status_t rx_status
);
	import spart_pkg::*;

	rx_state_t         state;
	// extra bit so the stop bit can run one tick past its middle
	logic [OS_CNT_W:0] os_cnt;
	logic [2:0]        bit_cnt;
	logic [7:0]        shreg;
	logic [7:0]        hold;
	logic              rxd_s1;
	logic              rxd_s2;
	logic              rxd_prev;
	logic              stop_ok;
	logic              rx_full;
	logic              overrun;
	logic              mid_bit;
	logic              commit;
	logic              load;

	////////////////////////////////////////////////////////////
	// input synchronizer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			rxd_s1   <= 1'b1;
			rxd_s2   <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_s1   <= rxd;
			rxd_s2   <= rxd_s1;
			rxd_prev <= rxd_s2;
		end
	end

	////////////////////////////////////////////////////////////
	// frame sequencer
	////////////////////////////////////////////////////////////

	assign mid_bit = tick && (os_cnt == (OS_CNT_W + 1)'(OVERSAMPLE - 1));
	// frame done one tick after the stop bit sample
	assign commit  = (state == RX_STOP) && tick && stop_ok &&
		(os_cnt == (OS_CNT_W + 1)'(OVERSAMPLE));
	// a byte that finds the holder full is dropped
	assign load    = commit && (!rx_full || rx_take);

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= RX_IDLE;
			os_cnt  <= '0;
			bit_cnt <= '0;
			stop_ok <= 1'b0;
		end else begin
			case (state)
				RX_IDLE: begin
					// falling edge on the synchronized line
					if (rxd_prev && !rxd_s2) begin
						state  <= RX_START;
						os_cnt <= '0;
					end
				end
				RX_START: begin
					if (tick && os_cnt == (OS_CNT_W + 1)'(HALF_BIT - 1)) begin
						// glitch if the line is back high at half a bit
						state   <= rxd_s2 ? RX_IDLE : RX_DATA;
						os_cnt  <= '0;
						bit_cnt <= '0;
					end else if (tick) begin
						os_cnt <= os_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (mid_bit) begin
						os_cnt  <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= RX_STOP;
						end
					end else if (tick) begin
						os_cnt <= os_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (tick) begin
						os_cnt <= os_cnt + 1'b1;
					end
					if (mid_bit) begin
						stop_ok <= rxd_s2;
					end
					if (tick && os_cnt == (OS_CNT_W + 1)'(OVERSAMPLE)) begin
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb arrives first, shift in from the top
	always_ff @(posedge clk) begin
		if (state == RX_DATA && mid_bit) begin
			shreg <= {rxd_s2, shreg[7:1]};
		end
		if (load) begin
			hold <= shreg;
		end
	end

	////////////////////////////////////////////////////////////
	// flags
	////////////////////////////////////////////////////////////

	// set wins over clear so no event is lost
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_full <= 1'b0;
			overrun <= 1'b0;
		end else begin
			if (rx_take) begin
				rx_full <= 1'b0;
			end
			if (status_clear) begin
				overrun <= 1'b0;
			end
			if (load) begin
				rx_full <= 1'b1;
			end else if (commit) begin
				overrun <= 1'b1;
			end
		end
	end

	assign rx_byte = hold;

	// tx_idle is filled in by the bus side
	always_comb begin
		rx_status         = '0;
		rx_status.rx_full = rx_full;
		rx_status.overrun = overrun;
	end

	// data reads only while a byte is held
	a_take_full: assert property (
		@(posedge clk) disable iff (rst)
		rx_take |-> rx_full
	);

endmodule

/* hdl/spart_top.sv */
`timescale 1ns/1ps

module spart_top (
	input  logic               clk,
	input  logic               rst,

	// cache controller port
	input  spart_pkg::io_req_t io_req,
	input  logic               io_valid,
	output logic               io_ready,
	output logic [31:0]        io_rd_data,

	// serial line
	output logic               txd,
	input  logic               rxd
);
	import spart_pkg::*;

	// shared oversample tick
	logic          tick;

	// bus side to transmitter
	logic          tx_start;
	logic [7:0]    tx_byte;
	logic          tx_idle;

	// bus side to receiver
	logic          rx_take;
	logic          status_clear;
	logic [7:0]    rx_byte;
	spart_status_t rx_status;

	////////////////////////////////////////////////////////////
	// bus bridge
	////////////////////////////////////////////////////////////

	spart_cache_interface if0 (
		.clk          (clk),
		.rst          (rst),
		.io_req       (io_req),
		.io_valid     (io_valid),
		.io_ready     (io_ready),
		.io_rd_data   (io_rd_data),
		.tx_start     (tx_start),
		.tx_byte      (tx_byte),
		.tx_idle      (tx_idle),
		.rx_byte      (rx_byte),
		.rx_status    (rx_status),
		.rx_take      (rx_take),
		.status_clear (status_clear)
	);

	////////////////////////////////////////////////////////////
	// serial engines
	////////////////////////////////////////////////////////////

	spart_baud_gen baud0 (
		.clk  (clk),
		.rst  (rst),
		.tick (tick)
	);

	spart_tx tx0 (
		.clk      (clk),
		.rst      (rst),
		.tick     (tick),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx_idle  (tx_idle),
		.txd      (txd)
	);

	spart_rx rx0 (
		.clk          (clk),
		.rst          (rst),
		.tick         (tick),
		.rxd          (rxd),
		.rx_take      (rx_take),
		.status_clear (status_clear),
		.rx_byte      (rx_byte),
		.rx_status    (rx_status)
	);

endmodule

/* tests/spart_checker.sv */
`timescale 1ns/1ps

module spart_checker (
	input  logic               clk,
	input  logic               rst,
	input  spart_pkg::io_req_t io_req,
	input  logic               io_valid,
	input  logic               io_ready,
	input  logic [31:0]        io_rd_data,
	input  logic               txd,
	input  int                 test_id,
	input  logic               test_done,
	input  logic [31:0]        exp_rd_data,
	output int                 errors,
	output int                 checks,
	output int                 frames
);
	import spart_pkg::*;

	// low bytes of every accepted write, in order
	logic [7:0] wr_log[$];
	int         rd_errs;
	int         rd_checks;
	int         fr_errs;
	int         fr_checks;
	int         errs_before;
	// frame rebuild state
	logic       in_frame;
	logic       prev_txd;
	int         cnt;
	int         slot;
	logic [7:0] line_byte;

	assign errors = rd_errs + fr_errs;
	assign checks = rd_checks + fr_checks;

	function automatic string test_label(int id);
		case (id)
			1:       return "reset_status";
			2:       return "tx_frame";
			3:       return "loopback_read";
			4:       return "busy_write";
			5:       return "overrun";
			6:       return "alias_read";
			default: return "startup";
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// bus side, one look per transfer edge
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (rst) begin
			rd_errs     <= 0;
			rd_checks   <= 0;
			errs_before <= 0;
		end else begin
			if (io_valid && io_ready && io_req.op == IO_WRITE) begin
				// every earlier byte must already be out
				if (wr_log.size() != frames) begin
					$display("write accepted while the previous frame was still on txd");
					rd_errs <= rd_errs + 1;
				end
				wr_log.push_back(io_req.wr_data[7:0]);
			end
			if (io_valid && io_ready && io_req.op == IO_READ) begin
				rd_checks <= rd_checks + 1;
				if (io_rd_data !== exp_rd_data) begin
					$display("Error %s: read of 0x%h expected 0x%h actual 0x%h",
						test_label(test_id), io_req.addr, exp_rd_data, io_rd_data);
					rd_errs <= rd_errs + 1;
				end
			end
			if (test_done) begin
				$display("test %0d %s: %0d errors, %s", test_id, test_label(test_id),
					errors - errs_before, (errors == errs_before) ? "ok" : "failed");
				errs_before <= errors;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// serial side, sampled at mid-bit
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (rst) begin
			in_frame  <= 1'b0;
			prev_txd  <= 1'b1;
			cnt       <= 0;
			slot      <= 0;
			fr_errs   <= 0;
			fr_checks <= 0;
			frames    <= 0;
		end else begin
			prev_txd <= txd;
			if (!in_frame) begin
				// nothing queued means the line sits at mark
				if (frames == wr_log.size() && txd !== 1'b1) begin
					$display("txd left the idle level with no byte to send");
					fr_errs <= fr_errs + 1;
				end
				if (prev_txd && !txd) begin
					in_frame <= 1'b1;
					cnt      <= BIT_CLKS / 2;
					slot     <= 0;
				end
			end else if (cnt > 1) begin
				cnt <= cnt - 1;
			end else begin
				cnt  <= BIT_CLKS;
				slot <= slot + 1;
				if (slot == 0) begin
					if (txd !== 1'b0) begin
						$display("Error %s: start bit expected 0 actual %b",
							test_label(test_id), txd);
						fr_errs <= fr_errs + 1;
					end
				end else if (slot <= 8) begin
					// lsb first
					line_byte <= {txd, line_byte[7:1]};
				end else begin
					in_frame  <= 1'b0;
					frames    <= frames + 1;
					fr_checks <= fr_checks + 1;
					if (frames >= wr_log.size()) begin
						$display("frame on txd with no write behind it");
						fr_errs <= fr_errs + 1;
					end else begin
						if (txd !== 1'b1) begin
							$display("Error %s: stop bit expected 1 actual %b",
								test_label(test_id), txd);
						end
						if (line_byte !== wr_log[frames]) begin
							$display("Error %s: frame expected 0x%h actual 0x%h",
								test_label(test_id), wr_log[frames], line_byte);
						end
						fr_errs <= fr_errs + int'(txd !== 1'b1) +
							int'(line_byte !== wr_log[frames]);
					end
				end
			end
		end
	end

endmodule

/* tests/spart_tb.sv */
`timescale 1ns/1ps

module spart_tb;
	import spart_pkg::*;

	// frames sent over the whole run
	localparam int NUM_FRAMES = 6;
	localparam int FRAME_CLKS = 10 * BIT_CLKS;
	localparam int TIMEOUT    = NUM_FRAMES * FRAME_CLKS * 2 + 500;

	logic        clk;
	logic        rst;
	io_req_t     io_req;
	logic        io_valid;
	logic        io_ready;
	logic [31:0] io_rd_data;
	logic        txd;
	logic        rxd;
	// line select: loopback or direct drive
	logic        loop_en;
	logic        rxd_force;
	int          test_id;
	logic        test_done;
	logic [31:0] exp_rd_data;
	int          errors;
	int          checks;
	int          frames;
	int          cycles = 0;

	// receive side model
	logic [7:0]  sent_q[$];
	logic [7:0]  mdl_byte;
	logic        mdl_full;
	logic        mdl_overrun;
	int          frames_modeled;

	always #50 clk = ~clk;

	assign rxd = loop_en ? txd : rxd_force;

	spart_top dut0 (
		.clk        (clk),
		.rst        (rst),
		.io_req     (io_req),
		.io_valid   (io_valid),
		.io_ready   (io_ready),
		.io_rd_data (io_rd_data),
		.txd        (txd),
		.rxd        (rxd)
	);

	spart_checker chk0 (
		.clk         (clk),
		.rst         (rst),
		.io_req      (io_req),
		.io_valid    (io_valid),
		.io_ready    (io_ready),
		.io_rd_data  (io_rd_data),
		.txd         (txd),
		.test_id     (test_id),
		.test_done   (test_done),
		.exp_rd_data (exp_rd_data),
		.errors      (errors),
		.checks      (checks),
		.frames      (frames)
	);

	// hard stop if a handshake or a frame never shows up
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("run stopped after %0d cycles, the tests did not finish", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// status is overrun, rx_full, tx_idle from bit 2 down
	// all status reads here happen with tx idle
	function automatic logic [31:0] expect_read(logic [27:0] addr);
		if (addr == ADDR_STATUS) begin
			return {29'd0, mdl_overrun, mdl_full, 1'b1};
		end
		return {24'd0, mdl_byte};
	endfunction

	task automatic model_after_read(logic [27:0] addr);
		if (addr == ADDR_STATUS) begin
			mdl_overrun = 1'b0;
		end else begin
			mdl_full = 1'b0;
		end
	endtask

	// finished frames fill the holder, or overrun when it is full
	task automatic model_arrivals();
		while (frames_modeled < frames) begin
			if (mdl_full) begin
				mdl_overrun = 1'b1;
			end else begin
				mdl_byte = sent_q[0];
				mdl_full = 1'b1;
			end
			void'(sent_q.pop_front());
			frames_modeled++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// bus tasks
	////////////////////////////////////////////////////////////

	// request held from a falling edge until ready
	task automatic handshake(io_req_t req);
		@(negedge clk);
		io_req   = req;
		io_valid = 1'b1;
		@(posedge clk);
		while (!io_ready) begin
			@(posedge clk);
		end
		@(negedge clk);
		io_valid = 1'b0;
	endtask

	task automatic io_write(logic [27:0] addr, logic [31:0] data);
		handshake('{op: IO_WRITE, addr: addr, wr_data: data});
		sent_q.push_back(data[7:0]);
	endtask

	task automatic io_read(logic [27:0] addr);
		exp_rd_data = expect_read(addr);
		handshake('{op: IO_READ, addr: addr, wr_data: 32'd0});
		model_after_read(addr);
	endtask

	// n frames seen on txd, then out to the end of the stop bit
	task automatic await_frames(int n);
		while (frames < n) begin
			@(negedge clk);
		end
		repeat (BIT_CLKS / 2 + 2 * BAUD_DIV) @(negedge clk);
		model_arrivals();
	endtask

	task automatic end_test();
		@(negedge clk);
		test_done = 1'b1;
		@(negedge clk);
		test_done = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		clk            = 1'b0;
		rst            = 1'b1;
		io_req         = '0;
		io_valid       = 1'b0;
		loop_en        = 1'b1;
		rxd_force      = 1'b1;
		test_id        = 0;
		test_done      = 1'b0;
		exp_rd_data    = '0;
		mdl_byte       = '0;
		mdl_full       = 1'b0;
		mdl_overrun    = 1'b0;
		frames_modeled = 0;
		void'($urandom(26384));
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// idle flags out of reset
		test_id = 1;
		io_read(ADDR_STATUS);
		// low pulse shorter than half a bit is no start bit
		@(negedge clk);
		loop_en   = 1'b0;
		rxd_force = 1'b0;
		repeat (BIT_CLKS / 4) @(negedge clk);
		rxd_force = 1'b1;
		repeat (FRAME_CLKS) @(negedge clk);
		loop_en = 1'b1;
		io_read(ADDR_STATUS);
		end_test();

		// one frame on the wire
		test_id = 2;
		io_write(ADDR_DATA, $urandom);
		await_frames(1);
		end_test();

		// byte comes back, then holder is empty
		test_id = 3;
		io_read(ADDR_DATA);
		io_read(ADDR_STATUS);
		end_test();

		// second write stalls behind the first frame
		test_id = 4;
		io_write(ADDR_DATA, $urandom);
		io_write(ADDR_DATA, $urandom);
		await_frames(2);
		io_read(ADDR_DATA);
		await_frames(3);
		io_read(ADDR_DATA);
		end_test();

		// two frames, no read between
		test_id = 5;
		io_write(ADDR_DATA, $urandom);
		io_write(ADDR_DATA, $urandom);
		await_frames(5);
		io_read(ADDR_DATA);
		io_read(ADDR_STATUS);
		io_read(ADDR_STATUS);
		end_test();

		// unmapped address aliases the data register
		test_id = 6;
		io_write(ADDR_DATA, $urandom);
		await_frames(6);
		io_read(28'h000_0040);
		io_read(ADDR_STATUS);
		end_test();

		repeat (4) @(negedge clk);
		$display("tests 6, checks %0d, errors %0d, frames %0d", checks, errors, frames);
		if (errors == 0 && frames == NUM_FRAMES) begin
			$display(">>> PASS");
		end else begin
			if (frames != NUM_FRAMES) begin
				$display("expected %0d frames on txd but saw %0d", NUM_FRAMES, frames);
			end
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* project.f */
hdl/spart_pkg.sv
hdl/spart_cache_interface.sv
hdl/spart_baud_gen.sv
hdl/spart_tx.sv
hdl/spart_rx.sv
hdl/spart_top.sv
tests/spart_checker.sv
tests/spart_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the spart testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

rm -rf "$build_dir"

verilator --binary --timing --assert -j 0 \
	--top-module spart_tb \
	-Mdir "$build_dir" -o spart_sim \
	-f project.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/spart_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# verdict comes from the log only
if grep -qx ">>> PASS" "$log_file"; then
	exit 0
fi
echo "pass line not found in $log_file"
exit 1
